/* test/sysctl_input.txt */
# columns: op arg1 arg2 arg3, all hex; R addr - exp, D addr exp exp+1, W addr data -
# H/F max cycles, S cycles level, P/U cycles, A cycles, G and X take no args
D 00 80000004 00000080
D 02 00000007 00000040
D 04 80000006 00000010
D 06 80000002 00000010
D 08 00000003 00000010
D 0a 80000005 00000010
D 0c 00000001 08000000
D 0e 00000000 00004000
D 10 00000000 00000400
R 12 0 00000000
R 1e 0 00000000
R 1f 0 00000000
W 1f 2 0
H 1 0 0
F 40 0 0
R 1f 0 00000000
U 3 0 0
F 40 0 0
P 5 0 0
F 40 0 0
A 20 0 0
G 0 0 0
W 1f 1 0
S 40 1 0
X 0 0 0
R 00 0 80000004

/* sysctl_top.f */
rtl/sysctl_pkg.sv
rtl/rst_seq.sv
rtl/devtbl.sv
rtl/activity_led.sv
rtl/sysctl_top.sv
test/sysctl_top_chk.sv
test/sysctl_top_tb.sv

/* run.sh */
#!/bin/sh
# compile and run with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
	-f sysctl_top.f --top-module sysctl_top_tb -o sim_sysctl
./obj_dir/sim_sysctl > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

/* test/sysctl_top_tb.sv */
// needs test/sysctl_input.txt relative to the run directory; expects RST_CNT_W=4 and ACT_CNT_W=3
`timescale 1ns/100ps

module sysctl_top_tb;
	import sysctl_pkg::*;

	localparam int RST_CNT_W     = 4;
	localparam int ACT_CNT_W     = 3;
	localparam int ACT_SRC_COUNT = 3;
	localparam int RST_LEN       = (1 << RST_CNT_W) - 1;
	localparam int ACT_PERIOD    = 1 << ACT_CNT_W;
	// longest command plus its idle gap, in clocks
	localparam int WORST_CMD_CYCLES = 96;

	logic                     clk_2x_w;
	logic                     rst_p;
	logic                     pll_locked_i;
	logic                     pu_rst_req_i;
	logic [ACT_SRC_COUNT-1:0] act_src_i;
	logic                     req_stb_i;
	logic                     req_we_i;
	reg_addr_t                req_addr_i;
	word_t                    req_wdata_i;
	logic                     rsp_stb_o;
	word_t                    rsp_rdata_o;
	logic                     sys_rst_o;
	logic                     activity_o;

	int word_errs;
	int bit_errs;
	int other_errs;

	byte   op_q[$];
	word_t arg1_q[$];
	word_t arg2_q[$];
	word_t arg3_q[$];

	sysctl_top #(
		.RST_CNT_W     (RST_CNT_W),
		.ACT_CNT_W     (ACT_CNT_W),
		.ACT_SRC_COUNT (ACT_SRC_COUNT)
	) sysctl_top_inst (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.pu_rst_req_i (pu_rst_req_i),
		.act_src_i    (act_src_i),
		.req_stb_i    (req_stb_i),
		.req_we_i     (req_we_i),
		.req_addr_i   (req_addr_i),
		.req_wdata_i  (req_wdata_i),
		.rsp_stb_o    (rsp_stb_o),
		.rsp_rdata_o  (rsp_rdata_o),
		.sys_rst_o    (sys_rst_o),
		.activity_o   (activity_o)
	);

	always #10 clk_2x_w = ~clk_2x_w;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
			word_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
			bit_errs++;
		end
	endtask

	task automatic report_other(input string what);
		$display("failure at %0t: %s", $time, what);
		other_errs++;
	endtask

	// holds rst_p for 10 clocks and checks the exact stretch length
	task automatic apply_reset();
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		repeat (10) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		for (int i = 0; i <= RST_LEN; i++) begin
			@(negedge clk_2x_w);
			if (i == 0) begin
				check_bit("rsp_stb_o", rsp_stb_o, 1'b0);
				check_bit("activity_o", activity_o, 1'b0);
			end
			check_bit("sys_rst_o", sys_rst_o, i < RST_LEN);
		end
	endtask

	task automatic bus_read(input reg_addr_t addr, input word_t exp);
		@(posedge clk_2x_w);
		req_stb_i  <= 1'b1;
		req_we_i   <= 1'b0;
		req_addr_i <= addr;
		@(posedge clk_2x_w);
		req_stb_i <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("rsp_stb_o", rsp_stb_o, 1'b1);
		check_word("rsp_rdata_o", rsp_rdata_o, exp);
	endtask

	// two reads on consecutive clocks, addr then addr+1
	task automatic bus_read_pair(input reg_addr_t addr, input word_t exp0, input word_t exp1);
		@(posedge clk_2x_w);
		req_stb_i  <= 1'b1;
		req_we_i   <= 1'b0;
		req_addr_i <= addr;
		@(posedge clk_2x_w);
		req_addr_i <= addr + 1'b1;
		@(negedge clk_2x_w);
		check_bit("rsp_stb_o", rsp_stb_o, 1'b1);
		check_word("rsp_rdata_o", rsp_rdata_o, exp0);
		@(posedge clk_2x_w);
		req_stb_i <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("rsp_stb_o", rsp_stb_o, 1'b1);
		check_word("rsp_rdata_o", rsp_rdata_o, exp1);
	endtask

	task automatic bus_write(input reg_addr_t addr, input word_t data);
		@(posedge clk_2x_w);
		req_stb_i   <= 1'b1;
		req_we_i    <= 1'b1;
		req_addr_i  <= addr;
		req_wdata_i <= data;
		@(posedge clk_2x_w);
		req_stb_i <= 1'b0;
		req_we_i  <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("rsp_stb_o", rsp_stb_o, 1'b1);
		check_word("rsp_rdata_o", rsp_rdata_o, '0);
	endtask

	task automatic wait_sys_rst(input logic level, input int limit);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge clk_2x_w);
			seen = (sys_rst_o === level);
		end
		if (!seen) begin
			report_other($sformatf("system reset did not reach %0d within %0d cycles",
				level, limit));
		end
	endtask

	task automatic hold_sys_rst(input int cycles, input logic level);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_2x_w);
			check_bit("sys_rst_o", sys_rst_o, level);
		end
	endtask

	// PLL drop with a read attempt that must be dropped
	task automatic drop_pll(input int cycles);
		@(posedge clk_2x_w);
		pll_locked_i <= 1'b0;
		@(posedge clk_2x_w);
		req_stb_i  <= 1'b1;
		req_we_i   <= 1'b0;
		req_addr_i <= '0;
		@(posedge clk_2x_w);
		req_stb_i <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("rsp_stb_o", rsp_stb_o, 1'b0);
		hold_sys_rst(cycles, 1'b1);
		@(posedge clk_2x_w);
		pll_locked_i <= 1'b1;
	endtask

	task automatic cpu_reset_request(input int cycles);
		@(posedge clk_2x_w);
		pu_rst_req_i <= 1'b1;
		repeat (cycles) @(posedge clk_2x_w);
		pu_rst_req_i <= 1'b0;
		@(negedge clk_2x_w);
		check_bit("sys_rst_o", sys_rst_o, 1'b1);
	endtask

	// steady sources, pulses must repeat every ACT_PERIOD clocks
	task automatic activity_burst(input int cycles);
		int first;
		first = -1;
		@(posedge clk_2x_w);
		act_src_i <= '1;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_2x_w);
			if (first < 0) begin
				if (activity_o === 1'b1) begin
					first = i;
				end
			end else begin
				check_bit("activity_o", activity_o, ((i - first) % ACT_PERIOD) == 0);
			end
		end
		if (first < 0) begin
			report_other("no activity pulse under steady sources");
		end
		@(posedge clk_2x_w);
		act_src_i <= '0;
	endtask

	// a short source pulse inside the hold-off is lost
	task automatic activity_holdoff();
		bit seen;
		seen = 1'b0;
		@(posedge clk_2x_w);
		act_src_i <= '1;
		for (int i = 0; i < 2 * ACT_PERIOD && !seen; i++) begin
			@(negedge clk_2x_w);
			seen = (activity_o === 1'b1);
		end
		if (!seen) begin
			report_other("activity pulse never appeared before hold-off test");
		end
		@(posedge clk_2x_w);
		act_src_i <= '0;
		@(posedge clk_2x_w);
		act_src_i <= 3'b001;
		@(posedge clk_2x_w);
		act_src_i <= '0;
		repeat (10) begin
			@(negedge clk_2x_w);
			check_bit("activity_o", activity_o, 1'b0);
		end
	endtask

	task automatic load_commands();
		int    fd;
		int    n;
		string line;
		byte   op;
		word_t a1;
		word_t a2;
		word_t a3;
		fd = $fopen("test/sysctl_input.txt", "r");
		if (fd == 0) begin
			report_other("cannot open test/sysctl_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%c %h %h %h", op, a1, a2, a3);
				if (n == 4) begin
					op_q.push_back(op);
					arg1_q.push_back(a1);
					arg2_q.push_back(a2);
					arg3_q.push_back(a3);
				end else begin
					report_other($sformatf("bad line in input file: %s", line));
				end
			end
		end
		$fclose(fd);
	endtask

	initial begin
		longint limit_ns;
		byte    op;
		clk_2x_w     = 1'b0;
		rst_p        = 1'b1;
		pll_locked_i = 1'b1;
		pu_rst_req_i = 1'b0;
		act_src_i    = '0;
		req_stb_i    = 1'b0;
		req_we_i     = 1'b0;
		req_addr_i   = '0;
		req_wdata_i  = '0;
		word_errs    = 0;
		bit_errs     = 0;
		other_errs   = 0;
		void'($urandom(32'h66e25032));
		load_commands();
		limit_ns = longint'(op_q.size() + 2) * WORST_CMD_CYCLES * 20;
		fork
			begin
				#(limit_ns);
				$display("watchdog expired before all commands finished");
				$display("Test failed");
				$finish;
			end
		join_none
		apply_reset();
		foreach (op_q[i]) begin
			op = op_q[i];
			// timing-sensitive follow-ups run without a gap
			if (op != "H" && op != "F" && op != "S") begin
				repeat ($urandom % 4) @(posedge clk_2x_w);
			end
			case (op)
				"R": bus_read(reg_addr_t'(arg1_q[i]), arg3_q[i]);
				"D": bus_read_pair(reg_addr_t'(arg1_q[i]), arg2_q[i], arg3_q[i]);
				"W": bus_write(reg_addr_t'(arg1_q[i]), arg2_q[i]);
				"H": wait_sys_rst(1'b1, int'(arg1_q[i]));
				"F": wait_sys_rst(1'b0, int'(arg1_q[i]));
				"S": hold_sys_rst(int'(arg1_q[i]), arg2_q[i][0]);
				"P": drop_pll(int'(arg1_q[i]));
				"U": cpu_reset_request(int'(arg1_q[i]));
				"A": activity_burst(int'(arg1_q[i]));
				"G": activity_holdoff();
				"X": apply_reset();
				default: report_other($sformatf("unknown command %c", op));
			endcase
		end
		repeat (4) @(posedge clk_2x_w);
		$display("errors: word=%0d bit=%0d other=%0d", word_errs, bit_errs, other_errs);
		if (word_errs + bit_errs + other_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* test/sysctl_top_chk.sv */
// protocol checks on the top-level ports, idle while rst_p is high
`timescale 1ns/100ps

module sysctl_top_chk (
	input logic clk_2x_w,
	input logic rst_p,
	input logic pll_locked_i,
	input logic req_stb_i,
	input logic rsp_stb_o,
	input logic sys_rst_o,
	input logic activity_o
);

	// no answer while the system is held in reset
	rsp_in_reset: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_stb_o |-> !sys_rst_o)
		else $error("response strobe during system reset");

	// every response needs a request taken one cycle before
	rsp_has_req: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_stb_o |-> $past(req_stb_i && !sys_rst_o))
		else $error("response strobe without an accepted request");

	// LED pulse is a single clock wide
	act_single: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		activity_o |=> !activity_o)
		else $error("activity high two cycles in a row");

	pll_forces_rst: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		!pll_locked_i |-> sys_rst_o)
		else $error("system reset low while PLL unlocked");

endmodule

bind sysctl_top sysctl_top_chk sysctl_top_chk_inst (
	.clk_2x_w     (clk_2x_w),
	.rst_p        (rst_p),
	.pll_locked_i (pll_locked_i),
	.req_stb_i    (req_stb_i),
	.rsp_stb_o    (rsp_stb_o),
	.sys_rst_o    (sys_rst_o),
	.activity_o   (activity_o)
);

/* rtl/sysctl_top.sv */
// system-control block alone; clock, PLL lock and processor reset request come from outside
`timescale 1ns/100ps

module sysctl_top import sysctl_pkg::*; #(
	parameter int RST_CNT_W     = 16,
	parameter int ACT_CNT_W     = 7,
	parameter int ACT_SRC_COUNT = 3
) (
	input  logic                     clk_2x_w,
	input  logic                     rst_p,
	input  logic                     pll_locked_i,
	input  logic                     pu_rst_req_i,
	input  logic [ACT_SRC_COUNT-1:0] act_src_i,
	input  logic                     req_stb_i,
	input  logic                     req_we_i,
	input  reg_addr_t                req_addr_i,
	input  word_t                    req_wdata_i,
	output logic                     rsp_stb_o,
	output word_t                    rsp_rdata_o,
	output logic                     sys_rst_o,
	output logic                     activity_o
);

	// software command from the register block into the sequencer
	rst_cmd_t rst_cmd;

	rst_seq #(
		.RST_CNT_W (RST_CNT_W)
	) rst_seq_inst (
		.clk_2x_w     (clk_2x_w),
		.rst_p        (rst_p),
		.pll_locked_i (pll_locked_i),
		.pu_rst_req_i (pu_rst_req_i),
		.rst_cmd_i    (rst_cmd),
		.sys_rst_o    (sys_rst_o)
	);

	// register block is held by the system reset it steers
	devtbl devtbl_inst (
		.clk_2x_w    (clk_2x_w),
		.sys_rst_i   (sys_rst_o),
		.req_stb_i   (req_stb_i),
		.req_we_i    (req_we_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.rsp_stb_o   (rsp_stb_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rst_cmd_o   (rst_cmd)
	);

	activity_led #(
		.ACT_CNT_W     (ACT_CNT_W),
		.ACT_SRC_COUNT (ACT_SRC_COUNT)
	) activity_led_inst (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.act_src_i  (act_src_i),
		.activity_o (activity_o)
	);

endmodule

/* rtl/activity_led.sv */
// pulse rate is one per 2^ACT_CNT_W clocks at most; runs through system reset and only rst_p clears it
`timescale 1ns/100ps

module activity_led #(
	parameter int ACT_CNT_W     = 7,
	parameter int ACT_SRC_COUNT = 3
) (
	input  logic                     clk_2x_w,
	input  logic                     rst_p,
	input  logic [ACT_SRC_COUNT-1:0] act_src_i,
	output logic                     activity_o
);

	typedef logic [ACT_CNT_W-1:0] act_cnt_t;

	act_cnt_t dim_cnt_r;
	logic     act_r;
	logic     src_any;

	// any source counts as activity
	assign src_any = |act_src_i;

	// short pulse followed by a hold-off keeps the LED dim
	// sources seen during the hold-off are simply lost
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			dim_cnt_r <= '0;
			act_r     <= 1'b0;
		end else if (dim_cnt_r != '0) begin
			dim_cnt_r <= dim_cnt_r - 1'b1;
			act_r     <= 1'b0;
		end else if (src_any) begin
			dim_cnt_r <= '1;
			act_r     <= 1'b1;
		end else begin
			act_r <= 1'b0;
		end
	end

	assign activity_o = act_r;

endmodule

/* rtl/devtbl.sv */
// one-cycle response with no back-pressure; requests during system reset or a pending reset command are dropped
`timescale 1ns/100ps

module devtbl import sysctl_pkg::*; (
	input  logic      clk_2x_w,
	input  logic      sys_rst_i,
	input  logic      req_stb_i,
	input  logic      req_we_i,
	input  reg_addr_t req_addr_i,
	input  word_t     req_wdata_i,
	output logic      rsp_stb_o,
	output word_t     rsp_rdata_o,
	output rst_cmd_t  rst_cmd_o
);

	rst_cmd_t cmd_r;
	logic     rsp_stb_r;
	word_t    rsp_rdata_r;
	dev_idx_t slot;
	logic     in_table;
	logic     is_ctrl;
	logic     cmd_pending;
	logic     accept;
	word_t    rd_word;

	// even word is id and interrupt flag, odd word is map size
	assign slot     = req_addr_i[4:1];
	assign in_table = (slot < dev_idx_t'(DEV_COUNT));
	assign is_ctrl  = (req_addr_i == CTRL_ADDR);

	// warm and power-off take the system down on the next edge
	// so nothing new is answered in between
	assign cmd_pending = (cmd_r == RST_CMD_WARM) || (cmd_r == RST_CMD_POWEROFF);

	assign accept = req_stb_i & ~sys_rst_i & ~cmd_pending;

	// read mux
	always_comb begin
		rd_word = '0;
		if (is_ctrl) begin
			rd_word[1:0] = cmd_r;
		end else if (in_table) begin
			if (req_addr_i[0]) begin
				rd_word = DEV_MAPSZ[slot];
			end else begin
				rd_word[3:0] = DEV_ID[slot];
				rd_word[31]  = DEV_USEINTR[slot];
			end
		end
	end

	// command register and response strobe
	// the system reset turns a warm command into a pulse
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			cmd_r     <= RST_CMD_NONE;
			rsp_stb_r <= 1'b0;
		end else begin
			rsp_stb_r <= accept;
			if (accept && req_we_i && is_ctrl) begin
				cmd_r <= rst_cmd_t'(req_wdata_i[1:0]);
			end
		end
	end

	// response data, zero for writes
	always_ff @(posedge clk_2x_w) begin
		if (accept) begin
			if (req_we_i) begin
				rsp_rdata_r <= '0;
			end else begin
				rsp_rdata_r <= rd_word;
			end
		end
	end

	assign rsp_stb_o   = rsp_stb_r;
	assign rsp_rdata_o = rsp_rdata_r;
	assign rst_cmd_o   = cmd_r;

endmodule

/* rtl/rst_seq.sv */
// counter and power-off latch are undefined until rst_p has been applied once with the clock running
`timescale 1ns/100ps

module rst_seq import sysctl_pkg::*; #(
	parameter int RST_CNT_W = 16
) (
	input  logic     clk_2x_w,
	input  logic     rst_p,
	input  logic     pll_locked_i,
	input  logic     pu_rst_req_i,
	input  rst_cmd_t rst_cmd_i,
	output logic     sys_rst_o
);

	typedef logic [RST_CNT_W-1:0] rst_cnt_t;

	// stretch length in clocks after the last reload
	localparam rst_cnt_t CNT_RELOAD = '1;

	rst_cnt_t rst_cnt_r;
	logic     pwroff_r;
	logic     warm_req;
	logic     pwroff_req;
	logic     cnt_reload;

	// command decode
	// cold is reserved and falls into the default arm
	always_comb begin
		warm_req   = 1'b0;
		pwroff_req = 1'b0;
		case (rst_cmd_i)
			RST_CMD_WARM: begin
				warm_req = 1'b1;
			end
			RST_CMD_POWEROFF: begin
				pwroff_req = 1'b1;
			end
			default: begin
				warm_req   = 1'b0;
				pwroff_req = 1'b0;
			end
		endcase
	end

	// any reset source restarts the whole stretch
	assign cnt_reload = rst_p | pu_rst_req_i | warm_req;

	always_ff @(posedge clk_2x_w) begin
		if (cnt_reload) begin
			rst_cnt_r <= CNT_RELOAD;
		end else if (rst_cnt_r != '0) begin
			rst_cnt_r <= rst_cnt_r - 1'b1;
		end
	end

	// power-off holds the system down until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_r <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_r <= 1'b1;
		end
	end

	// losing PLL lock forces reset at once, without waiting for the counter
	assign sys_rst_o = ~pll_locked_i | pwroff_r | (|rst_cnt_r);

endmodule

/* rtl/sysctl_pkg.sv */
// table contents are fixed at build time and the last slot is the catch-all for unmapped space
package sysctl_pkg;

	// register bus data word
	typedef logic [31:0] word_t;

	// word address on the register bus
	typedef logic [4:0] reg_addr_t;

	// device slot index, two bus words per slot
	typedef logic [3:0] dev_idx_t;

	// number of device slots in the table
	localparam int DEV_COUNT = 9;

	// software reset-command register sits at the top of the map
	localparam reg_addr_t CTRL_ADDR = 5'd31;

	// reset commands written by software
	// cold reset has no startup primitive behind it and acts as no command
	typedef enum logic [1:0] {
		RST_CMD_NONE     = 2'd0,
		RST_CMD_POWEROFF = 2'd1,
		RST_CMD_WARM     = 2'd2,
		RST_CMD_COLD     = 2'd3
	} rst_cmd_t;

	// slot order is sdcard, devtbl, gpio, dma, intctrl, uart, ram, ramctrl, invalid
	localparam logic [3:0] DEV_ID [0:DEV_COUNT-1] = '{
		4'd4, 4'd7, 4'd6, 4'd2, 4'd3, 4'd5, 4'd1, 4'd0, 4'd0
	};

	// slots that raise interrupts
	localparam logic DEV_USEINTR [0:DEV_COUNT-1] = '{
		1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0
	};

	// map size of each slot in words
	// ram covers 512MB and the invalid slot 4KB
	localparam word_t DEV_MAPSZ [0:DEV_COUNT-1] = '{
		32'h0000_0080,
		32'h0000_0040,
		32'h0000_0010,
		32'h0000_0010,
		32'h0000_0010,
		32'h0000_0010,
		32'h0800_0000,
		32'h0000_4000,
		32'h0000_0400
	};

endpackage
